// File: source/nf_ahb_pkg.sv
/*
 * AHB-Lite GPIO subsystem package
 * bus enums, request and response structs, the slave select field
 * of the address map and the GPIO register offsets
 */

`default_nettype none

package nf_ahb_pkg;

    // transfer type, htrans encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // slave response, only OKAY is ever driven
    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

    // register offsets, decoded from haddr[3:2]
    typedef enum logic [1:0] {
        GPIO_GPI = 2'b00,       // 0x0, input pins, read only
        GPIO_GPO = 2'b01,       // 0x4, output register
        GPIO_GPD = 2'b10        // 0x8, direction register
    } gpio_reg_e;

    localparam int GPIO_REG_MSB = 3;    // register offset field
    localparam int GPIO_REG_LSB = 2;

    // address phase plus write data, master to slave
    typedef struct packed {
        logic [31:0] haddr;
        logic [31:0] hwdata;    // valid one cycle after haddr
        logic        hwrite;
        htrans_e     htrans;
        logic [2:0]  hsize;     // carried, not decoded
        logic [2:0]  hburst;    // carried, not decoded
    } ahb_req_t;

    // slave to master
    typedef struct packed {
        logic [31:0] hrdata;
        hresp_e      hresp;
        logic        hready;
    } ahb_rsp_t;

    localparam int GPIO_SLV_N = 2;      // slaves behind the router

    // slave select field haddr[15:12]
    localparam int SLV_SEL_MSB = 15;
    localparam int SLV_SEL_LSB = 12;
    typedef logic [SLV_SEL_MSB-SLV_SEL_LSB:0] slv_sel_t;
    localparam slv_sel_t GPIO0_SEL = 4'h0;  // 8 bit port
    localparam slv_sel_t GPIO1_SEL = 4'h1;  // 16 bit port

endpackage : nf_ahb_pkg

`default_nettype wire

// File: source/nf_gpio.sv
/*
 * GPIO register core
 * output (GPO) and direction (GPD) registers written from the bus,
 * two flop synchronizer on the input pins (GPI), zero extended readback
 */

`default_nettype none

module nf_gpio #(
    parameter int gpio_w = 8
)(
    input  logic              hclk,
    input  logic              rst_n,
    // bus side
    input  logic [31:0]       addr,     // registered address phase
    input  logic              we,       // data phase write strobe
    input  logic [31:0]       wd,       // hwdata
    output logic [31:0]       rd,       // combinational read data
    // pin side
    input  logic [gpio_w-1:0] gpi,      // async input pins
    output logic [gpio_w-1:0] gpo,      // output value
    output logic [gpio_w-1:0] gpd       // direction, exported only
);

    nf_ahb_pkg::gpio_reg_e    reg_sel;  // decoded offset
    logic [gpio_w-1:0]        gpi_meta; // first sync stage
    logic [gpio_w-1:0]        gpi_sync; // second sync stage

    // offsets 0xC and up fall out of the enum and hit default
    assign reg_sel = nf_ahb_pkg::gpio_reg_e'(
        addr[nf_ahb_pkg::GPIO_REG_MSB:nf_ahb_pkg::GPIO_REG_LSB]);

    // input synchronizer
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end else begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
        end
    end

    // GPO and GPD, full word writes truncated to port width
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
            gpd <= '0;
        end else if (we) begin
            case (reg_sel)
                nf_ahb_pkg::GPIO_GPO: gpo <= wd[gpio_w-1:0];
                nf_ahb_pkg::GPIO_GPD: gpd <= wd[gpio_w-1:0];
                default: ;                  // GPI read only, 0xC ignored
            endcase
        end
    end

    // readback mux
    always_comb begin
        rd = '0;                            // upper bits stay zero
        case (reg_sel)
            nf_ahb_pkg::GPIO_GPI: rd[gpio_w-1:0] = gpi_sync;
            nf_ahb_pkg::GPIO_GPO: rd[gpio_w-1:0] = gpo;
            nf_ahb_pkg::GPIO_GPD: rd[gpio_w-1:0] = gpd;
            default:              rd = '0;  // unmapped offset
        endcase
    end

endmodule : nf_gpio

`default_nettype wire

// File: source/nf_ahb_gpio.sv
/*
 * AHB-Lite GPIO slave
 * registers the address phase, writes in the data phase and answers
 * reads from the register core, zero wait, one cycle hready pulse
 */

`default_nettype none

module nf_ahb_gpio #(
    parameter int gpio_w = 8
)(
    input  logic                 hclk,
    input  logic                 rst_n,
    // bus side
    input  logic                 hsel,      // from router decode
    input  nf_ahb_pkg::ahb_req_t req,
    output nf_ahb_pkg::ahb_rsp_t rsp,
    // pin side
    input  logic [gpio_w-1:0]    gpi,
    output logic [gpio_w-1:0]    gpo,
    output logic [gpio_w-1:0]    gpd
);

    logic        gpio_request;      // valid address phase for us
    logic        gpio_wrequest;     // ... and it is a write
    logic [31:0] gpio_addr;         // held address for data phase
    logic        gpio_we;           // data phase write strobe
    logic        hready_r;          // one cycle after each request
    logic [31:0] rd;                // core read data

    assign gpio_request  = hsel && (req.htrans != nf_ahb_pkg::IDLE);
    assign gpio_wrequest = gpio_request && req.hwrite;

    // address held only on accepted requests
    always_ff @(posedge hclk) begin
        if (gpio_request)
            gpio_addr <= req.haddr;
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_we  <= 1'b0;
            hready_r <= 1'b0;
        end else begin
            gpio_we  <= gpio_wrequest;
            hready_r <= gpio_request;
        end
    end

    always_comb begin
        rsp.hrdata = rd;                    // valid while hready high
        rsp.hresp  = nf_ahb_pkg::OKAY;
        rsp.hready = hready_r;
    end

    nf_gpio #(
        .gpio_w ( gpio_w     )
    ) gpio_core (
        .hclk   ( hclk       ),
        .rst_n  ( rst_n      ),
        .addr   ( gpio_addr  ),
        .we     ( gpio_we    ),
        .wd     ( req.hwdata ),  // data phase hwdata
        .rd     ( rd         ),
        .gpi    ( gpi        ),
        .gpo    ( gpo        ),
        .gpd    ( gpd        )
    );

endmodule : nf_ahb_gpio

`default_nettype wire

// File: source/nf_ahb_router.sv
/*
 * AHB-Lite router for the GPIO slaves
 * decodes haddr[15:12] into a one hot hsel and merges the slave
 * responses, read data follows whichever slave pulses hready
 */

`default_nettype none

module nf_ahb_router (
    // master side
    input  nf_ahb_pkg::ahb_req_t req,
    output nf_ahb_pkg::ahb_rsp_t rsp,
    // slave side
    output logic [nf_ahb_pkg::GPIO_SLV_N-1:0] hsel,
    input  nf_ahb_pkg::ahb_rsp_t              slv_rsp [nf_ahb_pkg::GPIO_SLV_N]
);

    nf_ahb_pkg::slv_sel_t slv_field;    // slave select bits

    assign slv_field = req.haddr[nf_ahb_pkg::SLV_SEL_MSB:nf_ahb_pkg::SLV_SEL_LSB];

    // address decode, htrans is left to the slaves
    always_comb begin
        hsel = '0;
        case (slv_field)
            nf_ahb_pkg::GPIO0_SEL: hsel[0] = 1'b1;
            nf_ahb_pkg::GPIO1_SEL: hsel[1] = 1'b1;
            default:               hsel = '0;      // unmapped, nobody answers
        endcase
    end

    /*
     * response merge
     * at most one slave pulses hready in a given cycle since only one
     * address phase is in flight, so the scan order does not matter.
     * an unmapped transfer leaves hready low and hrdata at zero
     */
    always_comb begin
        rsp        = '0;
        rsp.hresp  = nf_ahb_pkg::OKAY;     // no ERROR path
        for (int i = 0; i < nf_ahb_pkg::GPIO_SLV_N; i++) begin
            if (slv_rsp[i].hready) begin
                rsp.hready = 1'b1;
                rsp.hrdata = slv_rsp[i].hrdata;
            end
        end
    end

endmodule : nf_ahb_router

`default_nettype wire

// File: source/nf_ahb_gpio_sys.sv
/*
 * GPIO subsystem top level
 * one AHB-Lite port, router plus two GPIO slaves,
 * port 0 at slave field 0 and port 1 at slave field 1
 */

`default_nettype none

module nf_ahb_gpio_sys #(
    parameter int gpio0_w = 8,
    parameter int gpio1_w = 16
)(
    input  logic                 hclk,
    input  logic                 rst_n,
    // master port
    input  nf_ahb_pkg::ahb_req_t req,
    output nf_ahb_pkg::ahb_rsp_t rsp,
    // port 0 pins
    input  logic [gpio0_w-1:0]   gpio0_gpi,
    output logic [gpio0_w-1:0]   gpio0_gpo,
    output logic [gpio0_w-1:0]   gpio0_gpd,
    // port 1 pins
    input  logic [gpio1_w-1:0]   gpio1_gpi,
    output logic [gpio1_w-1:0]   gpio1_gpo,
    output logic [gpio1_w-1:0]   gpio1_gpd
);

    logic [nf_ahb_pkg::GPIO_SLV_N-1:0] hsel;                           // per slave select
    nf_ahb_pkg::ahb_rsp_t              slv_rsp [nf_ahb_pkg::GPIO_SLV_N]; // slave responses

    nf_ahb_router ahb_router (
        .req     ( req     ),
        .rsp     ( rsp     ),
        .hsel    ( hsel    ),
        .slv_rsp ( slv_rsp )
    );

    nf_ahb_gpio #(
        .gpio_w ( gpio0_w    )
    ) gpio_0 (
        .hclk   ( hclk       ),
        .rst_n  ( rst_n      ),
        .hsel   ( hsel[0]    ),
        .req    ( req        ),
        .rsp    ( slv_rsp[0] ),
        .gpi    ( gpio0_gpi  ),
        .gpo    ( gpio0_gpo  ),
        .gpd    ( gpio0_gpd  )
    );

    nf_ahb_gpio #(
        .gpio_w ( gpio1_w    )
    ) gpio_1 (
        .hclk   ( hclk       ),
        .rst_n  ( rst_n      ),
        .hsel   ( hsel[1]    ),
        .req    ( req        ),
        .rsp    ( slv_rsp[1] ),
        .gpi    ( gpio1_gpi  ),
        .gpo    ( gpio1_gpo  ),
        .gpd    ( gpio1_gpd  )
    );

endmodule : nf_ahb_gpio_sys

`default_nettype wire

// File: sim/nf_ahb_gpio_sys_chk.sv
/*
 * protocol checker for the AHB-Lite GPIO slave, bound into nf_ahb_gpio
 * hready only after a request, hresp always OKAY,
 * gpo and gpd change only after a write request
 */

`default_nettype none

module nf_ahb_gpio_sys_chk #(
    parameter int gpio_w = 8
)(
    input logic                 hclk,
    input logic                 rst_n,
    input logic                 hsel,
    input nf_ahb_pkg::ahb_req_t req,
    input nf_ahb_pkg::ahb_rsp_t rsp,
    input logic [gpio_w-1:0]    gpo,
    input logic [gpio_w-1:0]    gpd
);

    timeunit 1ns;
    timeprecision 100ps;

    logic request;      // address phase aimed at this slave
    logic wrequest;     // same, write

    assign request  = hsel && (req.htrans != nf_ahb_pkg::IDLE);
    assign wrequest = request && req.hwrite;

    ready_after_request: assert property (@(posedge hclk) disable iff (!rst_n)
        rsp.hready |-> $past(request))
        else $error("hready high without a request in the previous cycle");

    request_gets_ready: assert property (@(posedge hclk) disable iff (!rst_n)
        request |=> rsp.hready)
        else $error("request not answered by an hready pulse");

    hresp_okay: assert property (@(posedge hclk) disable iff (!rst_n)
        rsp.hresp == nf_ahb_pkg::OKAY)
        else $error("hresp is not OKAY");

    // pin update lands at edge N+1, seen as a change at edge N+2
    gpo_only_on_write: assert property (@(posedge hclk) disable iff (!rst_n)
        $changed(gpo) |-> $past(wrequest, 2))
        else $error("gpo changed without a write request");

    gpd_only_on_write: assert property (@(posedge hclk) disable iff (!rst_n)
        $changed(gpd) |-> $past(wrequest, 2))
        else $error("gpd changed without a write request");

endmodule : nf_ahb_gpio_sys_chk

bind nf_ahb_gpio nf_ahb_gpio_sys_chk #(
    .gpio_w ( gpio_w )
) u_gpio_chk (
    .hclk   ( hclk   ),
    .rst_n  ( rst_n  ),
    .hsel   ( hsel   ),
    .req    ( req    ),
    .rsp    ( rsp    ),
    .gpo    ( gpo    ),
    .gpd    ( gpd    )
);

`default_nettype wire

// File: sim/nf_ahb_gpio_sys_tb.sv
/*
 * directed testbench for the AHB-Lite GPIO subsystem
 * bus write and read tasks, reset values, readback, input sync,
 * unmapped space and back to back transfers
 */

`default_nettype none

module nf_ahb_gpio_sys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int gpio0_w        = 8;
    localparam int gpio1_w        = 16;
    localparam int clk_period     = 40;
    localparam int timeout_cycles = 200;    // tests need about 55 cycles

    localparam logic [31:0] port0_base    = 32'h0000_0000;
    localparam logic [31:0] port1_base    = 32'h0000_1000;
    localparam logic [31:0] unmapped_base = 32'h0000_2000;  // slave field 2
    localparam logic [31:0] off_gpi       = 32'h0;
    localparam logic [31:0] off_gpo       = 32'h4;
    localparam logic [31:0] off_gpd       = 32'h8;
    localparam logic [31:0] off_bad       = 32'hC;          // no register

    logic                 hclk;
    logic                 rst_n;
    nf_ahb_pkg::ahb_req_t req;
    nf_ahb_pkg::ahb_rsp_t rsp;
    logic [gpio0_w-1:0]   gpio0_gpi;
    logic [gpio0_w-1:0]   gpio0_gpo;
    logic [gpio0_w-1:0]   gpio0_gpd;
    logic [gpio1_w-1:0]   gpio1_gpi;
    logic [gpio1_w-1:0]   gpio1_gpo;
    logic [gpio1_w-1:0]   gpio1_gpd;

    integer seed   = 51;
    int     errors = 0;
    int     checks = 0;

    nf_ahb_gpio_sys #(
        .gpio0_w   ( gpio0_w   ),
        .gpio1_w   ( gpio1_w   )
    ) u_nf_ahb_gpio_sys (
        .hclk      ( hclk      ),
        .rst_n     ( rst_n     ),
        .req       ( req       ),
        .rsp       ( rsp       ),
        .gpio0_gpi ( gpio0_gpi ),
        .gpio0_gpo ( gpio0_gpo ),
        .gpio0_gpd ( gpio0_gpd ),
        .gpio1_gpi ( gpio1_gpi ),
        .gpio1_gpo ( gpio1_gpo ),
        .gpio1_gpd ( gpio1_gpd )
    );

    always #(clk_period / 2) hclk = ~hclk;

    // low width bits of a bus word, upper bits zero
    function automatic logic [31:0] trunc(input logic [31:0] value, input int width);
        return value & ((32'h1 << width) - 32'h1);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // one bus cycle, new address phase plus hwdata for the previous one
    task automatic bus_step(input logic [31:0] addr, input logic write, input logic active,
                            input logic [31:0] wdata, output nf_ahb_pkg::ahb_rsp_t sampled);
        @(negedge hclk);
        sampled    = rsp;               // answer to the previous address phase
        req.haddr  = addr;
        req.hwrite = write;
        if (active)
            req.htrans = nf_ahb_pkg::NONSEQ;
        else
            req.htrans = nf_ahb_pkg::IDLE;
        req.hwdata = wdata;
        req.hsize  = 3'b010;            // word
        req.hburst = 3'b000;            // single
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic mapped);
        nf_ahb_pkg::ahb_rsp_t r;
        bus_step(addr, 1'b1, 1'b1, '0, r);     // address phase
        bus_step('0, 1'b0, 1'b0, data, r);     // data phase
        check("rsp.hready", mapped, r.hready);
        check("rsp.hresp", nf_ahb_pkg::OKAY, r.hresp);
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                            input logic mapped);
        nf_ahb_pkg::ahb_rsp_t r;
        bus_step(addr, 1'b0, 1'b1, '0, r);
        bus_step('0, 1'b0, 1'b0, '0, r);
        check("rsp.hready", mapped, r.hready);
        check("rsp.hresp", nf_ahb_pkg::OKAY, r.hresp);
        data = r.hrdata;
    endtask

    task automatic reset_values();
        logic [31:0] rd;
        ahb_read(port0_base + off_gpo, rd, 1'b1);
        check("port0 GPO", 32'h0, rd);
        ahb_read(port0_base + off_gpd, rd, 1'b1);
        check("port0 GPD", 32'h0, rd);
        ahb_read(port1_base + off_gpo, rd, 1'b1);
        check("port1 GPO", 32'h0, rd);
        ahb_read(port1_base + off_gpd, rd, 1'b1);
        check("port1 GPD", 32'h0, rd);
        check("gpio0_gpo", 32'h0, gpio0_gpo);
        check("gpio0_gpd", 32'h0, gpio0_gpd);
        check("gpio1_gpo", 32'h0, gpio1_gpo);
        check("gpio1_gpd", 32'h0, gpio1_gpd);
    endtask

    // random GPO and GPD write, readback zero extended
    task automatic port_readback(input logic [31:0] base, input int width,
                                 output logic [31:0] gpo_exp, output logic [31:0] gpd_exp);
        logic [31:0] d_gpo;
        logic [31:0] d_gpd;
        logic [31:0] rd;
        d_gpo   = $random(seed);
        d_gpd   = $random(seed);
        gpo_exp = trunc(d_gpo, width);
        gpd_exp = trunc(d_gpd, width);
        ahb_write(base + off_gpo, d_gpo, 1'b1);
        ahb_write(base + off_gpd, d_gpd, 1'b1);
        ahb_read(base + off_gpo, rd, 1'b1);
        check("GPO readback", gpo_exp, rd);
        ahb_read(base + off_gpd, rd, 1'b1);
        check("GPD readback", gpd_exp, rd);
    endtask

    task automatic write_readback();
        logic [31:0] gpo_exp;
        logic [31:0] gpd_exp;
        port_readback(port0_base, gpio0_w, gpo_exp, gpd_exp);
        check("gpio0_gpo", gpo_exp, gpio0_gpo);
        check("gpio0_gpd", gpd_exp, gpio0_gpd);
        port_readback(port1_base, gpio1_w, gpo_exp, gpd_exp);
        check("gpio1_gpo", gpo_exp, gpio1_gpo);
        check("gpio1_gpd", gpd_exp, gpio1_gpd);
    endtask

    task automatic input_sync();
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] rd;
        v0 = $random(seed);
        v1 = $random(seed);
        @(negedge hclk);
        gpio0_gpi = v0[gpio0_w-1:0];
        gpio1_gpi = v1[gpio1_w-1:0];
        repeat (3) @(negedge hclk);            // past the two sync stages
        ahb_read(port0_base + off_gpi, rd, 1'b1);
        check("port0 GPI", trunc(v0, gpio0_w), rd);
        ahb_read(port1_base + off_gpi, rd, 1'b1);
        check("port1 GPI", trunc(v1, gpio1_w), rd);
    endtask

    task automatic unmapped_access();
        logic [31:0]        rd;
        logic [gpio0_w-1:0] p0_gpo;
        logic [gpio0_w-1:0] p0_gpd;
        logic [gpio1_w-1:0] p1_gpo;
        logic [gpio1_w-1:0] p1_gpd;
        p0_gpo = gpio0_gpo;
        p0_gpd = gpio0_gpd;
        p1_gpo = gpio1_gpo;
        p1_gpd = gpio1_gpd;
        ahb_write(unmapped_base + off_gpo, $random(seed), 1'b0);   // nobody answers
        ahb_read(unmapped_base + off_gpo, rd, 1'b0);
        check("unmapped slave read", 32'h0, rd);
        ahb_write(port0_base + off_bad, $random(seed), 1'b1);
        ahb_read(port0_base + off_bad, rd, 1'b1);
        check("port0 offset 0xC read", 32'h0, rd);
        ahb_write(port1_base + off_bad, $random(seed), 1'b1);
        ahb_read(port1_base + off_bad, rd, 1'b1);
        check("port1 offset 0xC read", 32'h0, rd);
        check("gpio0_gpo", p0_gpo, gpio0_gpo);
        check("gpio0_gpd", p0_gpd, gpio0_gpd);
        check("gpio1_gpo", p1_gpo, gpio1_gpo);
        check("gpio1_gpd", p1_gpd, gpio1_gpd);
    endtask

    // write p0, write p1, read p0, read p1 on consecutive cycles
    task automatic back_to_back();
        nf_ahb_pkg::ahb_rsp_t r;
        logic [31:0]          d0;
        logic [31:0]          d1;
        d0 = $random(seed);
        d1 = $random(seed);
        bus_step(port0_base + off_gpo, 1'b1, 1'b1, '0, r);
        bus_step(port1_base + off_gpo, 1'b1, 1'b1, d0, r);    // data of port0 write
        check("port0 write rsp.hready", 1'b1, r.hready);
        bus_step(port0_base + off_gpo, 1'b0, 1'b1, d1, r);    // data of port1 write
        check("port1 write rsp.hready", 1'b1, r.hready);
        bus_step(port1_base + off_gpo, 1'b0, 1'b1, '0, r);
        check("port0 read rsp.hready", 1'b1, r.hready);
        check("port0 read rsp.hrdata", trunc(d0, gpio0_w), r.hrdata);
        bus_step('0, 1'b0, 1'b0, '0, r);
        check("port1 read rsp.hready", 1'b1, r.hready);
        check("port1 read rsp.hrdata", trunc(d1, gpio1_w), r.hrdata);
        check("gpio0_gpo", trunc(d0, gpio0_w), gpio0_gpo);
        check("gpio1_gpo", trunc(d1, gpio1_w), gpio1_gpo);
    endtask

    initial begin
        #(timeout_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        hclk      = 1'b0;
        rst_n     = 1'b0;
        req       = '0;                 // IDLE
        gpio0_gpi = '0;
        gpio1_gpi = '0;
        repeat (2) @(negedge hclk);
        rst_n = 1'b1;
        reset_values();
        write_readback();
        input_sync();
        unmapped_access();
        back_to_back();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule : nf_ahb_gpio_sys_tb

`default_nettype wire

// File: nf_ahb_gpio_sys.f
source/nf_ahb_pkg.sv
source/nf_gpio.sv
source/nf_ahb_gpio.sv
source/nf_ahb_router.sv
source/nf_ahb_gpio_sys.sv
sim/nf_ahb_gpio_sys_chk.sv
sim/nf_ahb_gpio_sys_tb.sv

// File: Bender.yml
package:
  name: nf_ahb_gpio_sys

sources:
  # RTL in compile order
  - files:
      - source/nf_ahb_pkg.sv
      - source/nf_gpio.sv
      - source/nf_ahb_gpio.sv
      - source/nf_ahb_router.sv
      - source/nf_ahb_gpio_sys.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/nf_ahb_gpio_sys_chk.sv
      - sim/nf_ahb_gpio_sys_tb.sv
